// ==== compile.f ====
hdl/pong_field_pkg.sv
hdl/pong_regs_pkg.sv
hdl/pong_apb_regs.sv
hdl/pad_controller.sv
hdl/ball_controller.sv
hdl/score_controller.sv
hdl/pong_logic.sv
test/tb_clock.sv
test/tb_pong_logic.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f compile.f --top-module tb_pong_logic \
    -Mdir obj_dir -o sim_pong

./obj_dir/sim_pong > sim.log
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi

// ==== test/tb_pong_logic.sv ====
`timescale 1ns/1ps

module tb_pong_logic
    import pong_field_pkg::*;
    import pong_regs_pkg::*;
();

    localparam int ball_step = 4;
    localparam int pad_step = 8;
    localparam int win_score = 9;
    localparam int pad_ticks = 360;
    localparam int remote_ticks = 40;
    localparam int play_ticks = 4000;
    localparam int cycle_limit = 2 * (2 * pad_ticks + 5 * remote_ticks + 3 * play_ticks + 100);

    logic clk, reset, timing_tick, up1, down1, up2, down2;
    logic psel, penable, pwrite, pready, pslverr, game_over;
    logic [3:0] paddr, player1_score, player2_score;
    logic [31:0] pwdata, prdata, rdata;
    logic [x_width-1:0] x_ball;
    logic [y_width-1:0] y_ball, y_pad1, y_pad2, pos;
    logic [31:0] lfsr = 32'h843b;
    logic u1, d1, u2, d2, err;
    bit bdr, bdd, over, toward_top;
    int errors, property_errors, test_errors, tests_passed, tests_failed, cycles, n;
    int p1, p2, bx, by, s1, s2;

    tb_clock clock_gen (.clk);

    pong_logic #(.ball_step(ball_step), .pad_step(pad_step), .win_score(win_score)) UUT (.*);

    assert property (@(posedge clk) disable iff (reset)
                     int'(y_pad1) <= pad_y_max && int'(y_pad2) <= pad_y_max)
    else begin
        $display("A paddle left the field at %0t", $time);
        property_errors++;
    end

    assert property (@(posedge clk) pready)
    else begin
        $display("pready went low at %0t", $time);
        property_errors++;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("Timeout: the run went past %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic take_bit();
        lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);    // Galois form.
        return lfsr[0];
    endfunction

    function automatic logic biased_bit(input bit likely);
        if (likely)
            return take_bit() | take_bit() | take_bit();
        return take_bit() & take_bit() & take_bit();
    endfunction

    function automatic int pad_rule(input int cur, input logic up, input logic down);
        if (up && !down)
            return (cur < pad_step) ? 0 : cur - pad_step;
        if (down && !up)
            return (cur + pad_step > pad_y_max) ? pad_y_max : cur + pad_step;
        return cur;
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else begin
            $display("FAIL at %0t: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors + property_errors == test_errors) begin
            tests_passed++;
            $display("Test %s: ok", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed, %0d errors", name, errors + property_errors - test_errors);
        end
        test_errors = errors + property_errors;
    endtask

    task automatic tick(input logic bu1, input logic bd1, input logic bu2, input logic bd2);
        @(negedge clk);
        {up1, down1, up2, down2} = {bu1, bd1, bu2, bd2};
        timing_tick = 1'b1;
        @(negedge clk);
        timing_tick = 1'b0;
    endtask

    task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                              output logic [31:0] data, output logic error);
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = wdata;
        @(negedge clk);
        penable = 1'b1;
        #1;
        data = prdata;
        error = pslverr;
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic serve_model();
        bx = ball_x_center;
        by = ball_y_center;
        bdr = 1'b1;
        bdd = 1'b1;
        s1 = 0;
        s2 = 0;
        over = 1'b0;
    endtask

    // One frame with the ball model fed by the paddles seen before the tick.
    task automatic play_tick();
        int pl, pr, nx, ny;
        bit touch_l, touch_r;
        pl = int'(y_pad1);
        pr = int'(y_pad2);
        tick(take_bit(), take_bit(), take_bit(), take_bit());
        compare_value("player1_score", s1, int'(player1_score));    // Not yet counted.
        compare_value("player2_score", s2, int'(player2_score));
        if (!over) begin
            nx = bdr ? bx + ball_step : bx - ball_step;
            ny = bdd ? by + ball_step : by - ball_step;
            touch_l = (by + ball_size > pl) && (by < pl + pad_height);
            touch_r = (by + ball_size > pr) && (by < pr + pad_height);
            if (!bdd && ny <= 0) begin
                ny = 0;
                bdd = 1'b1;
            end else if (bdd && ny >= field_height - ball_size) begin
                ny = field_height - ball_size;
                bdd = 1'b0;
            end
            if (!bdr && touch_l && bx >= pad_left_x && nx <= pad_left_x) begin
                nx = pad_left_x;
                bdr = 1'b1;
            end else if (bdr && touch_r && bx + ball_size <= pad_right_x &&
                         nx + ball_size >= pad_right_x) begin
                nx = pad_right_x - ball_size;
                bdr = 1'b0;
            end else if (nx <= 0 || nx >= field_width - ball_size) begin
                if (nx <= 0)
                    s2++;    // Left player conceded.
                else
                    s1++;
                bdr = nx > 0;
                nx = ball_x_center;
                ny = ball_y_center;
            end
            bx = nx;
            by = ny;
            over = (s1 >= win_score) || (s2 >= win_score);
        end
        compare_value("x_ball", bx, int'(x_ball));
        compare_value("y_ball", by, int'(y_ball));
        @(negedge clk);
        compare_value("player1_score", s1, int'(player1_score));
        compare_value("player2_score", s2, int'(player2_score));
        compare_value("game_over", int'(over), int'(game_over));
    endtask

    initial begin
        {reset, timing_tick, up1, down1, up2, down2} = 6'b100000;
        {psel, penable, pwrite, paddr, pwdata} = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;

        compare_value("x_ball", ball_x_center, int'(x_ball));
        compare_value("y_ball", ball_y_center, int'(y_ball));
        compare_value("y_pad1", pad_y_max / 2, int'(y_pad1));
        compare_value("y_pad2", pad_y_max / 2, int'(y_pad2));
        compare_value("scores", 0, int'(player1_score) + int'(player2_score));
        compare_value("game_over", 0, int'(game_over));
        apb_access(1'b0, reg_score, '0, rdata, err);
        compare_value("prdata", 0, int'(rdata));
        finish_test("reset state");

        p1 = pad_y_max / 2;
        p2 = pad_y_max / 2;
        for (int i = 0; i < pad_ticks; i++) begin
            toward_top = ((i / 120) % 2) == 0;    // Long runs reach both limits.
            u1 = biased_bit(toward_top);
            d1 = biased_bit(!toward_top);
            u2 = biased_bit(!toward_top);
            d2 = biased_bit(toward_top);
            tick(u1, d1, u2, d2);
            p1 = pad_rule(p1, u1, d1);
            p2 = pad_rule(p2, u2, d2);
            compare_value("y_pad1", p1, int'(y_pad1));
            compare_value("y_pad2", p2, int'(y_pad2));
        end
        finish_test("paddle stepping");

        apb_access(1'b1, reg_control, 32'h1, rdata, err);
        compare_value("pslverr", 0, int'(err));
        apb_access(1'b0, reg_control, '0, rdata, err);
        compare_value("prdata", 1, int'(rdata));
        apb_access(1'b1, reg_control, 32'h0, rdata, err);
        apb_access(1'b0, reg_control, '0, rdata, err);
        compare_value("prdata", 0, int'(rdata));
        apb_access(1'b1, reg_pad2_pos, 32'h155, rdata, err);
        apb_access(1'b0, reg_pad2_pos, '0, rdata, err);
        compare_value("prdata", 'h155, int'(rdata));
        apb_access(1'b0, reg_ball, '0, rdata, err);
        compare_value("prdata", int'(x_ball) + 65536 * int'(y_ball), int'(rdata));
        apb_access(1'b1, reg_score, 32'hff, rdata, err);
        compare_value("pslverr", 1, int'(err));
        apb_access(1'b0, reg_score, '0, rdata, err);
        compare_value("prdata", int'(player1_score) + 16 * int'(player2_score) +
                      256 * int'(game_over), int'(rdata));
        apb_access(1'b0, 4'h2, '0, rdata, err);
        compare_value("pslverr", 1, int'(err));
        apb_access(1'b1, 4'h6, 32'hffff_ffff, rdata, err);
        compare_value("pslverr", 1, int'(err));
        apb_access(1'b0, reg_control, '0, rdata, err);
        compare_value("prdata", 0, int'(rdata));
        apb_access(1'b0, reg_pad2_pos, '0, rdata, err);
        compare_value("prdata", 'h155, int'(rdata));
        finish_test("register map");

        apb_access(1'b1, reg_control, 32'h1, rdata, err);
        for (int i = 0; i < remote_ticks; i++) begin
            for (int b = 0; b < y_width; b++)
                pos[b] = take_bit();
            apb_access(1'b1, reg_pad2_pos, 32'(pos), rdata, err);
            tick(1'b0, 1'b0, take_bit(), take_bit());    // Buttons must be ignored.
            p2 = (int'(pos) > pad_y_max) ? pad_y_max : int'(pos);
            compare_value("y_pad2", p2, int'(y_pad2));
        end
        finish_test("remote paddle");

        apb_access(1'b1, reg_control, 32'h2, rdata, err);    // Restart, local paddle.
        serve_model();
        n = 0;
        while (s1 + s2 < 3 && n < play_ticks) begin
            play_tick();
            n++;
        end
        if (s1 + s2 < 3) begin
            $display("Fewer than three goals were scored in %0d ticks", play_ticks);
            errors++;
        end
        finish_test("ball motion and scoring");

        while (!over && n < play_ticks) begin
            play_tick();
            n++;
        end
        if (!over) begin
            $display("No player reached the winning score in %0d ticks", play_ticks);
            errors++;
        end
        repeat (5) play_tick();    // Ball must stay frozen.
        apb_access(1'b0, reg_score, '0, rdata, err);
        compare_value("prdata", s1 + 16 * s2 + 256 * int'(over), int'(rdata));
        apb_access(1'b1, reg_control, 32'h2, rdata, err);
        serve_model();
        compare_value("x_ball", bx, int'(x_ball));
        compare_value("y_ball", by, int'(y_ball));
        compare_value("game_over", 0, int'(game_over));
        play_tick();
        finish_test("win and restart");

        $display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
        if (errors == 0 && property_errors == 0 && tests_failed == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

// ==== test/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int period = 4
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(period / 2) clk = ~clk;

endmodule

// ==== hdl/pong_logic.sv ====
`timescale 1ns/1ps

module pong_logic
    import pong_field_pkg::*;
#(
    parameter int ball_step = 4,
    parameter int pad_step  = 8,
    parameter int win_score = 9
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               timing_tick,
    input  logic               up1,
    input  logic               down1,
    input  logic               up2,
    input  logic               down2,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    output logic [x_width-1:0] x_ball,
    output logic [y_width-1:0] y_ball,
    output logic [y_width-1:0] y_pad1,
    output logic [y_width-1:0] y_pad2,
    output logic [3:0]         player1_score,
    output logic [3:0]         player2_score,
    output logic               game_over
);

    logic               remote_pad2;
    logic [y_width-1:0] pad2_pos;
    logic               restart;
    logic               goal_left;
    logic               goal_right;

    pong_apb_regs u_apb_regs (
        .clk,
        .reset,
        .psel,
        .penable,
        .pwrite,
        .paddr,
        .pwdata,
        .prdata,
        .pready,
        .pslverr,
        .player1_score,
        .player2_score,
        .game_over,
        .x_ball,
        .y_ball,
        .remote_pad2,
        .pad2_pos,
        .restart
    );

    pad_controller #(.pad_step(pad_step)) pad1 (
        .clk,
        .reset,
        .timing_tick,
        .up(up1),
        .down(down1),
        .use_ext(1'b0),    // Player 1 is always local.
        .ext_pos('0),
        .y_pad(y_pad1)
    );

    pad_controller #(.pad_step(pad_step)) pad2 (
        .clk,
        .reset,
        .timing_tick,
        .up(up2),
        .down(down2),
        .use_ext(remote_pad2),
        .ext_pos(pad2_pos),
        .y_pad(y_pad2)
    );

    ball_controller #(.ball_step(ball_step)) u_ball_controller (
        .clk,
        .reset,
        .timing_tick,
        .restart,
        .game_over,
        .y_pad_left(y_pad1),
        .y_pad_right(y_pad2),
        .x_ball,
        .y_ball,
        .goal_left,
        .goal_right
    );

    score_controller #(.win_score(win_score)) u_score_controller (
        .clk,
        .reset,
        .goal_left,
        .goal_right,
        .restart,
        .player1_score,
        .player2_score,
        .game_over
    );

endmodule

// ==== hdl/score_controller.sv ====
`timescale 1ns/1ps

module score_controller #(
    parameter int win_score = 9
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       goal_left,
    input  logic       goal_right,
    input  logic       restart,
    output logic [3:0] player1_score,
    output logic [3:0] player2_score,
    output logic       game_over
);

    logic [3:0] p1_next;
    logic [3:0] p2_next;
    logic       p1_wins;
    logic       p2_wins;

    // Goal against the left player counts for player 2.
    assign p1_next = player1_score + 4'd1;
    assign p2_next = player2_score + 4'd1;
    assign p1_wins = goal_right && (int'(p1_next) >= win_score);
    assign p2_wins = goal_left && (int'(p2_next) >= win_score);

    always_ff @(posedge clk) begin
        if (reset) begin
            player1_score <= '0;
            player2_score <= '0;
            game_over     <= 1'b0;
        end else if (restart) begin
            player1_score <= '0;
            player2_score <= '0;
            game_over     <= 1'b0;
        end else if (!game_over) begin
            if (goal_right)
                player1_score <= p1_next;
            if (goal_left)
                player2_score <= p2_next;
            if (p1_wins || p2_wins)
                game_over <= 1'b1;    // Same edge as the final score.
        end
    end

endmodule

// ==== hdl/ball_controller.sv ====
`timescale 1ns/1ps

module ball_controller
    import pong_field_pkg::*;
#(
    parameter int ball_step = 4
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               timing_tick,
    input  logic               restart,
    input  logic               game_over,
    input  logic [y_width-1:0] y_pad_left,
    input  logic [y_width-1:0] y_pad_right,
    output logic [x_width-1:0] x_ball,
    output logic [y_width-1:0] y_ball,
    output logic               goal_left,
    output logic               goal_right
);

    logic dir_right;
    logic dir_down;

    int x_try;
    int y_try;

    logic over_left;
    logic over_right;
    logic hit_left;
    logic hit_right;
    logic miss_left;
    logic miss_right;

    logic [x_width-1:0] x_next;
    logic [y_width-1:0] y_next;
    logic               dir_right_next;
    logic               dir_down_next;

    assign x_try = dir_right ? int'(x_ball) + ball_step : int'(x_ball) - ball_step;
    assign y_try = dir_down ? int'(y_ball) + ball_step : int'(y_ball) - ball_step;

    // Vertical overlap with each paddle.
    assign over_left  = (int'(y_ball) + ball_size > int'(y_pad_left)) &&
                        (int'(y_ball) < int'(y_pad_left) + pad_height);
    assign over_right = (int'(y_ball) + ball_size > int'(y_pad_right)) &&
                        (int'(y_ball) < int'(y_pad_right) + pad_height);

    // Leading edge reaches a face it had not passed yet.
    assign hit_left  = !dir_right && over_left &&
                       (int'(x_ball) >= pad_left_x) && (x_try <= pad_left_x);
    assign hit_right = dir_right && over_right &&
                       (int'(x_ball) + ball_size <= pad_right_x) &&
                       (x_try + ball_size >= pad_right_x);

    assign miss_left  = !dir_right && !hit_left && (x_try <= 0);
    assign miss_right = dir_right && !hit_right && (x_try >= ball_x_max);

    always_comb begin
        dir_down_next = dir_down;
        if (!dir_down && y_try <= 0) begin
            y_next        = '0;
            dir_down_next = 1'b1;
        end else if (dir_down && y_try >= ball_y_max) begin
            y_next        = y_width'(ball_y_max);
            dir_down_next = 1'b0;
        end else begin
            y_next = y_width'(y_try);
        end

        dir_right_next = dir_right;
        if (hit_left) begin
            x_next         = x_width'(pad_left_x);
            dir_right_next = 1'b1;
        end else if (hit_right) begin
            x_next         = x_width'(pad_right_x - ball_size);
            dir_right_next = 1'b0;
        end else if (miss_left || miss_right) begin
            x_next         = x_width'(ball_x_center);    // Serve.
            y_next         = y_width'(ball_y_center);
            dir_right_next = miss_right;    // Toward the player who conceded.
        end else begin
            x_next = x_width'(x_try);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            x_ball     <= x_width'(ball_x_center);
            y_ball     <= y_width'(ball_y_center);
            dir_right  <= 1'b1;
            dir_down   <= 1'b1;
            goal_left  <= 1'b0;
            goal_right <= 1'b0;
        end else begin
            goal_left  <= 1'b0;
            goal_right <= 1'b0;
            if (restart) begin
                x_ball    <= x_width'(ball_x_center);
                y_ball    <= y_width'(ball_y_center);
                dir_right <= 1'b1;
                dir_down  <= 1'b1;
            end else if (timing_tick && !game_over) begin
                x_ball     <= x_next;
                y_ball     <= y_next;
                dir_right  <= dir_right_next;
                dir_down   <= dir_down_next;
                goal_left  <= miss_left;
                goal_right <= miss_right;
            end
        end
    end

endmodule

// ==== hdl/pad_controller.sv ====
`timescale 1ns/1ps

module pad_controller
    import pong_field_pkg::*;
#(
    parameter int pad_step = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               timing_tick,
    input  logic               up,
    input  logic               down,
    input  logic               use_ext,
    input  logic [y_width-1:0] ext_pos,
    output logic [y_width-1:0] y_pad
);

    logic [y_width-1:0] y_next;

    always_comb begin
        y_next = y_pad;
        if (use_ext) begin
            if (int'(ext_pos) > pad_y_max)
                y_next = y_width'(pad_y_max);
            else
                y_next = ext_pos;
        end else if (up && !down) begin
            if (int'(y_pad) < pad_step)
                y_next = '0;    // Stop at the top.
            else
                y_next = y_pad - y_width'(pad_step);
        end else if (down && !up) begin
            if (int'(y_pad) > pad_y_max - pad_step)
                y_next = y_width'(pad_y_max);    // Stop at the bottom.
            else
                y_next = y_pad + y_width'(pad_step);
        end
    end

    always_ff @(posedge clk) begin
        if (reset)
            y_pad <= y_width'(pad_y_max / 2);
        else if (timing_tick)
            y_pad <= y_next;
    end

endmodule

// ==== hdl/pong_apb_regs.sv ====
`timescale 1ns/1ps

module pong_apb_regs
    import pong_field_pkg::*;
    import pong_regs_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [3:0]           paddr,
    input  logic [31:0]          pwdata,
    output logic [31:0]          prdata,
    output logic                 pready,
    output logic                 pslverr,
    input  logic [3:0]           player1_score,
    input  logic [3:0]           player2_score,
    input  logic                 game_over,
    input  logic [x_width-1:0]   x_ball,
    input  logic [y_width-1:0]   y_ball,
    output logic                 remote_pad2,
    output logic [y_width-1:0]   pad2_pos,
    output logic                 restart
);

    logic access;
    logic addr_ok;
    logic read_only;
    logic wr_en;

    assign access = psel && penable;
    assign pready = 1'b1;    // No wait states.

    always_comb begin
        addr_ok   = 1'b1;
        read_only = 1'b0;
        case (paddr)
            reg_control, reg_pad2_pos: read_only = 1'b0;
            reg_score, reg_ball:       read_only = 1'b1;
            default:                   addr_ok   = 1'b0;
        endcase
    end

    assign wr_en   = access && pwrite && addr_ok && !read_only;
    assign pslverr = access && (!addr_ok || (pwrite && read_only));

    // Pulse lasts exactly the access cycle.
    assign restart = wr_en && (paddr == reg_control) && pwdata[ctrl_restart_bit];

    always_ff @(posedge clk) begin
        if (reset) begin
            remote_pad2 <= 1'b0;
            pad2_pos    <= '0;
        end else if (wr_en) begin
            if (paddr == reg_control)
                remote_pad2 <= pwdata[ctrl_remote_bit];
            if (paddr == reg_pad2_pos)
                pad2_pos <= pwdata[y_width-1:0];
        end
    end

    // Read words built from live game state.
    always_comb begin
        prdata = '0;
        case (paddr)
            reg_control: prdata[ctrl_remote_bit] = remote_pad2;
            reg_pad2_pos: prdata[y_width-1:0] = pad2_pos;
            reg_score: begin
                prdata[score_p1_lsb +: 4]   = player1_score;
                prdata[score_p2_lsb +: 4]   = player2_score;
                prdata[score_over_bit]      = game_over;
            end
            reg_ball: begin
                prdata[ball_x_lsb +: x_width] = x_ball;
                prdata[ball_y_lsb +: y_width] = y_ball;
            end
            default: prdata = '0;
        endcase
    end

endmodule

// ==== hdl/pong_regs_pkg.sv ====
package pong_regs_pkg;

    // Register offsets.
    localparam logic [3:0] reg_control  = 4'h0;
    localparam logic [3:0] reg_pad2_pos = 4'h4;
    localparam logic [3:0] reg_score    = 4'h8;    // Read only.
    localparam logic [3:0] reg_ball     = 4'hc;    // Read only.

    // Control register bits.
    localparam int ctrl_remote_bit  = 0;
    localparam int ctrl_restart_bit = 1;    // Self clearing.

    // Score word layout.
    localparam int score_p1_lsb   = 0;
    localparam int score_p2_lsb   = 4;
    localparam int score_over_bit = 8;

    // Ball word layout.
    localparam int ball_x_lsb = 0;
    localparam int ball_y_lsb = 16;

endpackage

// ==== hdl/pong_field_pkg.sv ====
package pong_field_pkg;

    // Playing field in pixels.
    localparam int field_width  = 1024;
    localparam int field_height = 768;

    // Coordinate widths.
    localparam int x_width = 11;
    localparam int y_width = 10;

    // Object sizes.
    localparam int pad_height = 64;
    localparam int ball_size  = 8;    // Square ball.

    // Inner faces of the paddles.
    localparam int pad_left_x  = 16;
    localparam int pad_right_x = 1000;

    // Lowest paddle top position.
    localparam int pad_y_max = field_height - pad_height;

    // Serve position, ball top left corner.
    localparam int ball_x_center = (field_width - ball_size) / 2;
    localparam int ball_y_center = (field_height - ball_size) / 2;

    // Furthest ball top left corner positions.
    localparam int ball_x_max = field_width - ball_size;
    localparam int ball_y_max = field_height - ball_size;

endpackage
